// ==== aer_readout_top.f ====
verilog/aer_pkg.sv
verilog/timestamp_counter.sv
verilog/event_fifo.sv
verilog/event_capture.sv
verilog/event_data_encoder.sv
verilog/aer_readout_top.sv
sim/aer_readout_sva.sv
sim/aer_readout_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the AER readout testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

top=aer_readout_tb
build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module "$top" -f aer_readout_top.f --Mdir "$build_dir" -o "$top"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/$top" > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qx "PASS: all tests" "$log"; then
  echo "Result: passed"
  exit 0
else
  echo "Result: failed"
  exit 1
fi

// ==== sim/aer_readout_tb.sv ====
// AER readout testbench; LFSR events with reader stalls and enable gaps, checked by a model
`timescale 1ns/100ps

module aer_readout_tb;

  import aer_pkg::*;

  localparam int TICK_DIV     = 1;
  localparam int EVT_DEPTH    = 4;
  localparam int OUT_DEPTH    = 4;
  localparam int CLK_PERIOD   = 4;                       // ns
  localparam int RESET_CYCLES = 8;
  localparam int ROUNDS       = 4;
  localparam int BATCH        = 60;                      // Events per batch, two per round
  localparam int N_EVENTS     = ROUNDS * 2 * BATCH;
  localparam int MAX_STRETCH  = 64;                      // Longest stall or enable gap
  localparam int CYC_PER_EVT  = 12;                      // Gap up to 7, strobe, two words
  localparam int WATCHDOG_CYC = RESET_CYCLES + N_EVENTS * CYC_PER_EVT
                                + ROUNDS * 2 * MAX_STRETCH + 200;

  logic               clk_i;
  logic               reset_i;
  logic               enable_i;
  logic               ev_strobe_i;
  logic               ev_polarity_i;
  logic [ROW_ADD-1:0] ev_row_i;
  logic [COL_ADD-1:0] ev_col_i;
  logic               rd_i;
  logic [WIDTH-1:0]   word_o;
  logic               empty_o;
  logic [15:0]        drop_count_o;

  logic [31:0]        lfsr;                              // Stimulus LFSR state
  logic [SIZE-1:0]    model_ts;                          // Mirror of the DUT timestamp
  int                 model_div;
  event_t             sent_q[$];                         // Strobed events, oldest first
  int                 sent_total;
  int                 rx_cd;                             // CD words received
  logic               have_high;                         // Any time-high seen since reset
  logic [TS_HIGH-1:0] model_high;                        // Last high bits emitted
  logic               th_pending;                        // Time-high waiting for its CD word
  logic [WIDTH-1:0]   th_word;

  aer_readout_top #(
    .TICK_DIV      (TICK_DIV),
    .EVT_DEPTH     (EVT_DEPTH),
    .OUT_DEPTH     (OUT_DEPTH)
  ) DUT (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .enable_i      (enable_i),
    .ev_strobe_i   (ev_strobe_i),
    .ev_polarity_i (ev_polarity_i),
    .ev_row_i      (ev_row_i),
    .ev_col_i      (ev_col_i),
    .rd_i          (rd_i),
    .word_o        (word_o),
    .empty_o       (empty_o),
    .drop_count_o  (drop_count_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Galois LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic compare_word(input logic [WIDTH-1:0] got, input logic [WIDTH-1:0] exp,
                              input string what);
    if (got !== exp)
      stop_with_failure($sformatf("mismatch at %0t ns: %s got %h expected %h",
                                  $time, what, got, exp));
  endtask

  task automatic compare_drops(input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp)
      stop_with_failure($sformatf("mismatch at %0t ns: drop count got %0d expected %0d",
                                  $time, got, exp));
  endtask

  task automatic compare_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
      stop_with_failure($sformatf("mismatch at %0t ns: %s got %b expected %b",
                                  $time, what, got, exp));
  endtask

  // Applies the word format rules to one popped word
  task automatic score_word(input logic [WIDTH-1:0] w);
    event_t             ev;
    logic [TS_HIGH-1:0] exp_high;
    logic [TYPE_W-1:0]  exp_type;
    int                 idx;
    if (w[WIDTH-1 -: TYPE_W] == EVT_TIME_HIGH)
    begin
      if (th_pending)
        stop_with_failure($sformatf("error at %0t ns: two time-high words in a row", $time));
      th_pending = 1'b1;
      th_word    = w;
    end
    else
    begin
      idx = -1;                                          // Match by address, skipping drops
      for (int k = 0; k < sent_q.size() && idx < 0; k++)
        if (sent_q[k].row == w[COL_ADD +: ROW_ADD] && sent_q[k].col == w[COL_ADD-1:0])
          idx = k;
      if (idx < 0)
        stop_with_failure($sformatf("error at %0t ns: word %h matches no sent event",
                                    $time, w));
      for (int k = 0; k < idx; k++)
        sent_q.delete(0);                                // Dropped in the DUT
      ev       = sent_q.pop_front();
      exp_high = ev.ts[SIZE-1:TS_LOW];
      if (!have_high || exp_high != model_high)
      begin
        if (!th_pending)
          stop_with_failure($sformatf("error at %0t ns: time-high word missing before %h",
                                      $time, w));
        compare_word(th_word, {EVT_TIME_HIGH, exp_high}, "time-high word");
        have_high  = 1'b1;
        model_high = exp_high;
        th_pending = 1'b0;
      end
      else if (th_pending)
        stop_with_failure($sformatf("error at %0t ns: time-high word %h not needed",
                                    $time, th_word));
      exp_type = ev.polarity ? EVT_CD_ON : EVT_CD_OFF;
      compare_word(w, {exp_type, ev.ts[TS_LOW-1:0], ev.row, ev.col}, "CD word");
      rx_cd++;
    end
  endtask

  // Timestamp mirror, one tick per TICK_DIV cycles after reset release
  always @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
    begin
      model_div <= 0;
      model_ts  <= '0;
    end
    else if (model_div == TICK_DIV - 1)
    begin
      model_div <= 0;
      model_ts  <= model_ts + 1'b1;
    end
    else
      model_div <= model_div + 1;
  end

  // Records strobed events and scores popped words, all from pre-edge values
  always @(posedge clk_i)
  begin
    if (reset_i)
    begin
      sent_q.delete();
      sent_total = 0;
      rx_cd      = 0;
      have_high  = 1'b0;
      model_high = '0;
      th_pending = 1'b0;
      th_word    = '0;
    end
    else
    begin
      if (ev_strobe_i)
      begin
        sent_q.push_back({ev_polarity_i, ev_row_i, ev_col_i, model_ts});
        sent_total++;
      end
      if (rd_i && !empty_o)
        score_word(word_o);
    end
  end

  task automatic drive_cycle(input logic strobe, input logic rd, input logic en);
    logic [31:0] pol;
    logic [31:0] row;
    logic [31:0] col;
    if (strobe)
    begin
      draw(1, pol);
      draw(ROW_ADD, row);
      draw(COL_ADD, col);
    end
    @(posedge clk_i);
    ev_strobe_i <= strobe;
    if (strobe)
    begin
      ev_polarity_i <= pol[0];
      ev_row_i      <= row[ROW_ADD-1:0];
      ev_col_i      <= col[COL_ADD-1:0];
    end
    rd_i     <= rd;
    enable_i <= en;
  endtask

  // Random gaps of 0 to 7 cycles, reader busy one cycle in four
  task automatic send_events(input int n);
    logic [31:0] gap;
    logic [31:0] rd_bits;
    for (int i = 0; i < n; i++)
    begin
      draw(3, gap);
      repeat (gap)
      begin
        draw(2, rd_bits);
        drive_cycle(1'b0, rd_bits != 0, 1'b1);
      end
      draw(2, rd_bits);
      drive_cycle(1'b1, rd_bits != 0, 1'b1);
    end
  endtask

  // Reader halted while events keep coming, so both queues fill
  task automatic stall_reader(input int len);
    logic [15:0] drops_before;
    @(negedge clk_i);
    drops_before = drop_count_o;
    repeat (len)
      drive_cycle(1'b1, 1'b0, 1'b1);
    @(negedge clk_i);
    if (drop_count_o == drops_before)
      stop_with_failure($sformatf("error at %0t ns: no event dropped during reader stall",
                                  $time));
  endtask

  // Encoder off; output must drain and then stay empty
  task automatic idle_stretch(input int len);
    logic        drained;
    logic [31:0] strobe_bit;
    drained = 1'b0;
    for (int c = 0; c < len; c++)
    begin
      draw(1, strobe_bit);
      drive_cycle(strobe_bit[0], 1'b1, 1'b0);
      @(negedge clk_i);
      if (drained)
        compare_flag(empty_o, 1'b1, "empty_o with encoder disabled");
      else if (empty_o)
        drained = 1'b1;
    end
    if (!drained)
      stop_with_failure($sformatf("error at %0t ns: output did not drain with encoder off",
                                  $time));
  endtask

  // Run until the output has been empty for several cycles
  task automatic drain_output();
    int quiet;
    quiet = 0;
    while (quiet < 8)
    begin
      drive_cycle(1'b0, 1'b1, 1'b1);
      @(negedge clk_i);
      quiet = empty_o ? quiet + 1 : 0;
    end
  endtask

  initial
  begin : stimulus
    logic [31:0] len;
    lfsr           = 32'h9413;
    reset_i       <= 1'b1;
    enable_i      <= 1'b0;
    ev_strobe_i   <= 1'b0;
    ev_polarity_i <= 1'b0;
    ev_row_i      <= '0;
    ev_col_i      <= '0;
    rd_i          <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;
    for (int r = 0; r < ROUNDS; r++)
    begin
      send_events(BATCH);
      draw(5, len);
      stall_reader(32 + len);
      send_events(BATCH);
      draw(5, len);
      idle_stretch(16 + len);
    end
    drain_output();
    if (th_pending)
      stop_with_failure("error: time-high word left without a following CD word");
    compare_drops(drop_count_o, 16'(sent_total - rx_cd));
    $display("PASS: all tests");
    $finish;
  end

  // Bound from event count and worst cycles per event
  initial
  begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    stop_with_failure($sformatf("error at %0t ns: watchdog expired, run did not finish",
                                $time));
  end

endmodule

// ==== sim/aer_readout_sva.sv ====
// Concurrent checks on the event encoder, bound into event_data_encoder for every simulation
`timescale 1ns/100ps

module aer_readout_sva (
  input logic clk_i,
  input logic reset_i,
  input logic enable_i,
  input logic evt_empty_i,        // Event queue empty
  input logic out_full_i,         // Output queue full
  input logic pop_i,              // Encoder pop strobe
  input logic valid_data_i        // Encoder write strobe
);

  // Pop needs an event at the head
  pop_not_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    pop_i |-> !evt_empty_i)
    else $error("encoder popped an empty event queue");

  // Never push into a full word queue
  write_not_full: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_data_i |-> !out_full_i)
    else $error("encoder wrote into a full output queue");

  // Quiet while disabled
  idle_when_off: assert property (@(posedge clk_i) disable iff (reset_i)
    !enable_i |-> !valid_data_i)
    else $error("encoder wrote a word while disabled");

endmodule

bind event_data_encoder aer_readout_sva u_sva (
  .clk_i        (clk_i),
  .reset_i      (reset_i),
  .enable_i     (enable_i),
  .evt_empty_i  (evt_empty_i),
  .out_full_i   (out_full_i),
  .pop_i        (pop_o),
  .valid_data_i (valid_data_o)
);

// ==== verilog/aer_readout_top.sv ====
// Top level of the DVS event readout; timestamp, capture, event queue, encoder and word queue
`timescale 1ns/100ps

module aer_readout_top #(
  parameter int TICK_DIV  = 4,                          // Clocks per timestamp tick
  parameter int EVT_DEPTH = aer_pkg::EVT_DEPTH_DEF,     // Event queue entries
  parameter int OUT_DEPTH = aer_pkg::OUT_DEPTH_DEF      // Word queue entries
) (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        enable_i,         // Encoder enable level
  input  logic                        ev_strobe_i,      // Pixel event pulse
  input  logic                        ev_polarity_i,
  input  logic [aer_pkg::ROW_ADD-1:0] ev_row_i,
  input  logic [aer_pkg::COL_ADD-1:0] ev_col_i,
  input  logic                        rd_i,             // Reader pops a word
  output logic [aer_pkg::WIDTH-1:0]   word_o,           // Head word
  output logic                        empty_o,          // Low when word_o is valid
  output logic [15:0]                 drop_count_o      // Events lost to a full queue
);

  import aer_pkg::*;

  logic [SIZE-1:0]  ts;                                 // Shared timestamp
  logic             evt_wr;                             // Capture to event queue
  event_t           evt_wdata;
  logic             evt_full;
  event_t           evt_head;                           // Event queue to encoder
  logic             evt_empty;
  logic             evt_pop;
  logic [WIDTH-1:0] enc_word;                           // Encoder to word queue
  logic             enc_valid;
  logic             out_full;

  timestamp_counter #(
    .TICK_DIV (TICK_DIV)
  ) u_ts (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .ts_o     (ts)
  );

  event_capture u_capture (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .ev_strobe_i   (ev_strobe_i),
    .ev_polarity_i (ev_polarity_i),
    .ev_row_i      (ev_row_i),
    .ev_col_i      (ev_col_i),
    .ts_i          (ts),
    .fifo_full_i   (evt_full),
    .wr_o          (evt_wr),
    .wdata_o       (evt_wdata),
    .drop_count_o  (drop_count_o)
  );

  // Stamped events
  event_fifo #(
    .T       (event_t),
    .DEPTH   (EVT_DEPTH)
  ) u_evt_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .wr_i    (evt_wr),
    .wdata_i (evt_wdata),
    .rd_i    (evt_pop),
    .rdata_o (evt_head),
    .empty_o (evt_empty),
    .full_o  (evt_full)
  );

  event_data_encoder u_encoder (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .enable_i     (enable_i),
    .evt_empty_i  (evt_empty),
    .evt_i        (evt_head),
    .out_full_i   (out_full),
    .pop_o        (evt_pop),
    .data_out_o   (enc_word),
    .valid_data_o (enc_valid)
  );

  // Readout words for the external reader
  event_fifo #(
    .T       (logic [WIDTH-1:0]),
    .DEPTH   (OUT_DEPTH)
  ) u_out_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .wr_i    (enc_valid),
    .wdata_i (enc_word),
    .rd_i    (rd_i),
    .rdata_o (word_o),
    .empty_o (empty_o),
    .full_o  (out_full)
  );

endmodule

// ==== verilog/event_data_encoder.sv ====
// Event encoder; turns queued events into time-high and CD readout words, one word per cycle
`timescale 1ns/100ps

module event_data_encoder (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      enable_i,      // Encoder runs only while high
  input  logic                      evt_empty_i,   // Event queue empty
  input  aer_pkg::event_t           evt_i,         // Head of event queue
  input  logic                      out_full_i,    // Output queue full
  output logic                      pop_o,         // Pop head event
  output logic [aer_pkg::WIDTH-1:0] data_out_o,    // Word to output queue
  output logic                      valid_data_o   // Output queue push
);

  import aer_pkg::*;

  // Head event fields
  logic [TS_HIGH-1:0] head_high;                   // Upper timestamp bits
  logic [TS_LOW-1:0]  head_low;                    // Low bits sent in CD word
  logic [TYPE_W-1:0]  cd_type;                     // ON or OFF code

  // Tracking of the last time-high word sent
  logic [TS_HIGH-1:0] last_high;
  logic               high_sent;                   // Any time-high since reset

  logic               act;                         // Encoder acts this cycle
  logic               need_high;                   // Head needs time-high first
  logic [WIDTH-1:0]   th_word;
  logic [WIDTH-1:0]   cd_word;

  assign head_high = evt_i.ts[SIZE-1:TS_LOW];
  assign head_low  = evt_i.ts[TS_LOW-1:0];
  assign cd_type   = evt_i.polarity ? EVT_CD_ON : EVT_CD_OFF;

  // Work needs input, room at output and enable
  assign act = enable_i && !evt_empty_i && !out_full_i;

  // Compare against last high bits rather than waiting for low bits at 63
  // Covers skipped ticks and idle gaps longer than one low-bit period
  assign need_high = !high_sent || (head_high != last_high);

  // Word formats, both 32 bits
  assign th_word = {EVT_TIME_HIGH, head_high};                   // 4 + 28
  assign cd_word = {cd_type, head_low, evt_i.row, evt_i.col};    // 4 + 6 + 11 + 11

  // Time-high takes a cycle without popping, CD word pops the event
  always_comb
  begin
    valid_data_o = act;
    pop_o        = 1'b0;
    data_out_o   = cd_word;
    if (need_high)
      data_out_o = th_word;
    else
      pop_o = act;                                 // Event done after its CD word
  end

  // Remember high bits once the time-high word is written
  always_ff @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
    begin
      high_sent <= 1'b0;                           // First event always gets time-high
      last_high <= '0;
    end
    else if (act && need_high)
    begin
      high_sent <= 1'b1;
      last_high <= head_high;
    end
  end

endmodule

// ==== verilog/event_capture.sv ====
// Pixel event input; stamps each strobe with the current timestamp, queues it or counts a drop
`timescale 1ns/100ps

module event_capture (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        ev_strobe_i,    // One-cycle pulse per event
  input  logic                        ev_polarity_i,
  input  logic [aer_pkg::ROW_ADD-1:0] ev_row_i,
  input  logic [aer_pkg::COL_ADD-1:0] ev_col_i,
  input  logic [aer_pkg::SIZE-1:0]    ts_i,           // Free-running timestamp
  input  logic                        fifo_full_i,    // Event queue full
  output logic                        wr_o,           // Event queue push
  output aer_pkg::event_t             wdata_o,
  output logic [15:0]                 drop_count_o    // Saturating lost-event count
);

  import aer_pkg::*;

  event_t stamped;                                    // Event with its timestamp
  logic   drop;                                       // Strobe hit a full queue

  // Stamp in the strobe cycle
  always_comb
  begin
    stamped.polarity = ev_polarity_i;
    stamped.row      = ev_row_i;
    stamped.col      = ev_col_i;
    stamped.ts       = ts_i;
  end

  // Write goes out the same cycle, so full is exact here
  assign wr_o    = ev_strobe_i && !fifo_full_i;
  assign wdata_o = stamped;
  assign drop    = ev_strobe_i && fifo_full_i;

  // Drop counter holds at all ones
  always_ff @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
      drop_count_o <= '0;
    else if (drop && !(&drop_count_o))
      drop_count_o <= drop_count_o + 16'd1;
  end

endmodule

// ==== verilog/event_fifo.sv ====
// Show-ahead synchronous FIFO for any payload type; holds stamped events or readout words
`timescale 1ns/100ps

module event_fifo #(
  parameter type T     = logic [31:0],         // Payload type
  parameter int  DEPTH = 8                     // Number of entries
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic wr_i,                           // Push wdata_i, blocked when full
  input  T     wdata_i,
  input  logic rd_i,                           // Pop head, ignored when empty
  output T     rdata_o,                        // Head entry, valid while not empty
  output logic empty_o,
  output logic full_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);    // Holds 0..DEPTH

  T                 mem [DEPTH];               // Storage, no reset
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;                     // Occupancy
  logic             do_wr;
  logic             do_rd;

  // Guarded strobes
  assign do_wr = wr_i && !full_o;
  assign do_rd = rd_i && !empty_o;

  assign empty_o = (count == '0);
  assign full_o  = (count == CNT_W'(DEPTH));
  assign rdata_o = mem[rd_ptr];                // Show-ahead head

  always_ff @(posedge clk_i)
  begin
    if (do_wr)
      mem[wr_ptr] <= wdata_i;
  end

  // Pointers wrap at DEPTH so any depth works
  always_ff @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
    end
  end

  // Occupancy; simultaneous push and pop leave it unchanged
  always_ff @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
      count <= '0;
    else if (do_wr && !do_rd)
      count <= count + 1'b1;
    else if (do_rd && !do_wr)
      count <= count - 1'b1;
  end

endmodule

// ==== verilog/timestamp_counter.sv ====
// Free-running event timestamp; one tick every TICK_DIV clocks, shared by capture and encoder
`timescale 1ns/100ps

module timestamp_counter #(
  parameter int TICK_DIV = 4                   // Clock cycles per timestamp tick
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  output logic [aer_pkg::SIZE-1:0] ts_o        // Completed ticks since reset release
);

  // Prescaler needs at least one bit even for TICK_DIV of 1
  localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

  logic [DIV_W-1:0] div_cnt;                   // Cycles into current tick
  logic             tick;                      // Last cycle of a tick

  assign tick = (div_cnt == DIV_W'(TICK_DIV - 1));

  // Prescaler
  always_ff @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
      div_cnt <= '0;
    else if (tick)
      div_cnt <= '0;                           // Restart for next tick
    else
      div_cnt <= div_cnt + 1'b1;
  end

  // Timestamp, wraps at full width
  always_ff @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
      ts_o <= '0;
    else if (tick)
      ts_o <= ts_o + 1'b1;
  end

endmodule

// ==== verilog/aer_pkg.sv ====
// Shared widths, word type codes, default depths and the event record for the AER readout path
package aer_pkg;

  // Address and timestamp widths
  localparam int ROW_ADD = 11;               // Row address bits
  localparam int COL_ADD = 11;               // Column address bits
  localparam int SIZE    = 34;               // Full timestamp width
  localparam int TS_LOW  = 6;                // Low timestamp field in CD words
  localparam int TS_HIGH = SIZE - TS_LOW;    // Upper bits carried by time-high words

  // Output word layout
  localparam int WIDTH  = 32;                // Readout word width
  localparam int TYPE_W = 4;                 // Type code in the top nibble

  // Type codes
  localparam logic [TYPE_W-1:0] EVT_TIME_HIGH = 4'b1000;
  localparam logic [TYPE_W-1:0] EVT_CD_ON     = 4'b0001;  // Positive contrast change
  localparam logic [TYPE_W-1:0] EVT_CD_OFF    = 4'b0000;  // Negative contrast change

  // Default queue depths, overridden from the top level
  localparam int EVT_DEPTH_DEF = 16;
  localparam int OUT_DEPTH_DEF = 8;

  // Stamped address event as queued between capture and encoder
  // 1 + 11 + 11 + 34 = 57 bits
  typedef struct packed {
    logic               polarity;  // 1 for ON event
    logic [ROW_ADD-1:0] row;
    logic [COL_ADD-1:0] col;
    logic [SIZE-1:0]    ts;        // Timestamp at strobe time
  } event_t;

endpackage
